// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := fetch_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulation output is searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fetch_addr_gen.sv
// Restart keeps the current stream; only a redirect opens a new one, and the stream tag wraps at 16
`default_nettype none

`include "fetch_macros.svh"

module fetch_addr_gen
	import fetch_addr_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        en_i,
	input  wire logic        restart_i,
	input  wire fetch_addr_t restart_pc_i,
	input  wire logic        redirect_i,
	input  wire fetch_addr_t redirect_pc_i,
	output pc_tagged_t       pc_o
);

	pc_tagged_t pc_q;
	pc_tagged_t pc_d;

	// ====================
	// Next address
	// ====================

	// Restart beats redirect, and both beat the sequential step
	always_comb begin
		pc_d = pc_q;
		if (restart_i) begin
			pc_d.pc = restart_pc_i;
		end else if (redirect_i) begin
			// The target starts a new stream so older lines can be told apart
			pc_d.pc     = redirect_pc_i;
			pc_d.stream = pc_q.stream + stream_t'(1);
		end else if (en_i) begin
			pc_d.pc = pc_q.pc + fetch_addr_t'(`FETCH_LINE_BYTES);
		end
	end

	// A redirect or restart during a stall replaces the line not yet latched
	// When stalled with neither, the address simply holds
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q.stream <= stream_t'(1);
			pc_q.pc     <= '0;
		end else begin
			pc_q <= pc_d;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: hw/fetch_addr_pkg.sv
// Address, stream and fetch-bundle types; needs fetch_line_pkg compiled first for the line type
`default_nettype none

`include "fetch_macros.svh"

package fetch_addr_pkg;

	import fetch_line_pkg::*;

	// Byte address of an instruction or line
	typedef logic [31:0] fetch_addr_t;

	// Stream tag, bumped by every redirect
	typedef logic [3:0] stream_t;

	// Address tagged with the stream it was fetched in
	typedef struct packed {
		stream_t     stream;
		fetch_addr_t pc;
	} pc_tagged_t;

	// ====================
	// Registered result of one fetch
	// ====================

	typedef struct packed {
		pc_tagged_t [`FETCH_SLOTS-1:0] slot_pc;
		fetch_line_t                   line;
		logic                          flush;
		logic                          irq;
		logic [2:0]                    uop_num;
		// Set when the line was replaced by NOPs
		logic                          squashed;
	} fetch_bundle_t;

endpackage

`default_nettype wire

// File: hw/fetch_cfg_regs.sv
// Config port is always ready; inject slots are written one at a time and the slot 4 write arms the line
`default_nettype none

`include "fetch_macros.svh"

module fetch_cfg_regs
	import fetch_addr_pkg::*;
	import fetch_line_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        cfg_valid_i,
	input  wire cfg_wr_t     cfg_wr_i,
	output logic             restart_o,
	output fetch_addr_t      restart_pc_o,
	output stream_t          kept_stream_o,
	output logic             store_we_o,
	output logic [2:0]       store_idx_o,
	output logic [2:0]       store_slot_o,
	output logic [47:0]      store_data_o,
	output logic             inject_o,
	output fetch_line_t      inject_line_o,
	input  wire logic        inject_taken_i
);

	logic slot_ok;
	logic inject_wr;

	// Slot selects 5 to 7 have no storage behind them
	assign slot_ok   = cfg_wr_i.slot < 3'(`FETCH_SLOTS);
	assign inject_wr = cfg_valid_i && (cfg_wr_i.sel == CFG_INJECT) && slot_ok;

	// Go is a pulse in the write cycle so the generator restarts at the next edge
	assign restart_o = cfg_valid_i && (cfg_wr_i.sel == CFG_GO);

	// Line store writes pass straight through, the store commits them at the next edge
	assign store_we_o   = cfg_valid_i && (cfg_wr_i.sel == CFG_STORE);
	assign store_idx_o  = cfg_wr_i.idx;
	assign store_slot_o = cfg_wr_i.slot;
	assign store_data_o = cfg_wr_i.data;

	// ====================
	// Control registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			restart_pc_o  <= '0;
			// Matches the stream the generator comes out of reset with
			kept_stream_o <= stream_t'(1);
			inject_o      <= 1'b0;
		end else begin
			if (cfg_valid_i && cfg_wr_i.sel == CFG_RESTART)
				restart_pc_o <= cfg_wr_i.data[31:0];
			if (cfg_valid_i && cfg_wr_i.sel == CFG_KEPT)
				kept_stream_o <= cfg_wr_i.data[3:0];
			// A fresh arm wins over the stage taking the previous line
			if (inject_wr && cfg_wr_i.slot == 3'(`FETCH_SLOTS - 1))
				inject_o <= 1'b1;
			else if (inject_taken_i)
				inject_o <= 1'b0;
		end
	end

	// Inject line payload
	always_ff @(posedge clk) begin
		if (inject_wr)
			inject_line_o[cfg_wr_i.slot].raw <= cfg_wr_i.data;
	end

endmodule

`default_nettype wire

// File: hw/fetch_line_pkg.sv
// Instruction slot and line layout plus the configuration-write format; compile before fetch_addr_pkg
`default_nettype none

`include "fetch_macros.svh"

package fetch_line_pkg;

	// Decoded view of one six-byte instruction slot
	typedef struct packed {
		logic [6:0]  opcode;
		logic        marker;
		logic [39:0] operand;
	} insn_fields_t;

	// The same 48 bits are handled as a raw word by the store and as fields by the stage
	typedef union packed {
		logic [47:0]  raw;
		insn_fields_t f;
	} insn_slot_u;

	// Slot 0 sits at the lowest address of the line
	typedef insn_slot_u [`FETCH_SLOTS-1:0] fetch_line_t;

	// Register select of a configuration write
	typedef enum logic [2:0] {
		CFG_RESTART = 3'd0,
		CFG_KEPT    = 3'd1,
		CFG_STORE   = 3'd2,
		CFG_INJECT  = 3'd3,
		CFG_GO      = 3'd4
	} cfg_sel_e;

	typedef struct packed {
		cfg_sel_e    sel;
		logic [2:0]  idx;
		logic [2:0]  slot;
		logic [47:0] data;
	} cfg_wr_t;

endpackage

`default_nettype wire

// File: hw/fetch_line_store.sv
// Direct-mapped by line number modulo 8; only lines 0 to 7 (bytes 0 to 239) can ever hit
`default_nettype none

`include "fetch_macros.svh"

module fetch_line_store
	import fetch_addr_pkg::*;
	import fetch_line_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        we_i,
	input  wire logic [2:0]  idx_i,
	input  wire logic [2:0]  slot_i,
	input  wire logic [47:0] data_i,
	input  wire fetch_addr_t pc_i,
	output logic             hit_o,
	output fetch_line_t      line_o
);

	fetch_line_t lines [`FETCH_STORE_LINES];
	fetch_addr_t tags [`FETCH_STORE_LINES];
	logic [`FETCH_STORE_LINES-1:0] valid_q;
	logic [2:0] rd_idx;
	logic       slot_ok;

	assign slot_ok = slot_i < 3'(`FETCH_SLOTS);

	// ====================
	// Lookup
	// ====================

	// Line number is the address over the line size, the divisor is a constant
	assign rd_idx = 3'(pc_i / fetch_addr_t'(`FETCH_LINE_BYTES));

	// The tag check rejects addresses that alias onto a line from beyond the store
	assign hit_o  = valid_q[rd_idx] && (tags[rd_idx] == pc_i);
	assign line_o = lines[rd_idx];

	// ====================
	// Write side
	// ====================

	always_ff @(posedge clk) begin
		if (we_i && slot_ok)
			lines[idx_i][slot_i].raw <= data_i;
		// Slot 0 opens the line, so its tag is set here
		if (we_i && slot_i == 3'd0)
			tags[idx_i] <= fetch_addr_t'(idx_i) * fetch_addr_t'(`FETCH_LINE_BYTES);
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else if (we_i && slot_i == 3'd0)
			valid_q[idx_i] <= 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
// Output stays valid once fetch starts; flush and irq pulses seen during a stall wait for the next latch
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage
	import fetch_addr_pkg::*;
	import fetch_line_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire pc_tagged_t  pc_i,
	input  wire logic        hit_i,
	input  wire fetch_line_t line_i,
	input  wire logic        inject_i,
	input  wire fetch_line_t inject_line_i,
	output logic             inject_taken_o,
	input  wire stream_t     kept_stream_i,
	input  wire logic        flush_i,
	input  wire logic        irq_i,
	input  wire logic [2:0]  uop_num_i,
	output logic             bundle_valid_o,
	input  wire logic        bundle_ready_i,
	output fetch_bundle_t    bundle_o,
	output logic             en_o
);

	pc_tagged_t [`FETCH_SLOTS-1:0] slot_pc;
	fetch_line_t sel_line;
	logic        squash;
	logic        flush_pend;
	logic        irq_pend;
	logic [2:0]  uop_hold;
	logic        flush_eff;
	logic        irq_eff;

	// Load a new bundle when the register is empty or its bundle leaves this cycle
	assign en_o           = !bundle_valid_o || bundle_ready_i;
	assign inject_taken_o = en_o && inject_i;

	assign flush_eff = flush_i || flush_pend;
	assign irq_eff   = irq_i || irq_pend;

	// A miss, a flush or a line from a stale stream is turned into NOPs
	assign squash = !hit_i || flush_eff || (pc_i.stream != kept_stream_i);

	// ====================
	// Slot addresses and line select
	// ====================

	always_comb begin
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			slot_pc[i].stream = pc_i.stream;
			slot_pc[i].pc     = pc_i.pc + fetch_addr_t'(i * `FETCH_SLOT_BYTES);
		end
	end

	always_comb begin
		sel_line = line_i;
		for (int i = 0; i < `FETCH_SLOTS; i++) begin
			if (inject_i) begin
				// Injected slots are marked so decode can tell them from fetched ones
				sel_line[i]          = inject_line_i[i];
				sel_line[i].f.marker = 1'b1;
			end else if (squash) begin
				sel_line[i].f.opcode  = `FETCH_OP_NOP;
				sel_line[i].f.marker  = 1'b0;
				sel_line[i].f.operand = '0;
			end
		end
	end

	// ====================
	// Registers
	// ====================

	// Side-band pulses that arrive while stalled are held so none is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			bundle_valid_o <= 1'b0;
			flush_pend     <= 1'b0;
			irq_pend       <= 1'b0;
		end else begin
			if (en_o)
				bundle_valid_o <= 1'b1;
			flush_pend <= !en_o && flush_eff;
			irq_pend   <= !en_o && irq_eff;
		end
	end

	// The micro-op number travels with the irq pulse that it belongs to
	always_ff @(posedge clk) begin
		if (irq_i && !irq_pend)
			uop_hold <= uop_num_i;
	end

	always_ff @(posedge clk) begin
		if (en_o) begin
			bundle_o.slot_pc  <= slot_pc;
			bundle_o.line     <= sel_line;
			bundle_o.flush    <= flush_eff;
			bundle_o.irq      <= irq_eff;
			bundle_o.uop_num  <= irq_pend ? uop_hold : uop_num_i;
			bundle_o.squashed <= !inject_i && squash;
		end
	end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
// Fetch runs from address 0 out of reset; unloaded lines come out as squashed NOP bundles until go
`default_nettype none

module fetch_top
	import fetch_addr_pkg::*;
	import fetch_line_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        cfg_valid_i,
	input  wire cfg_wr_t     cfg_wr_i,
	input  wire logic        redirect_i,
	input  wire fetch_addr_t redirect_pc_i,
	input  wire logic        flush_i,
	input  wire logic        irq_i,
	input  wire logic [2:0]  uop_num_i,
	output logic             bundle_valid_o,
	input  wire logic        bundle_ready_i,
	output fetch_bundle_t    bundle_o
);

	logic        restart;
	fetch_addr_t restart_pc;
	stream_t     kept_stream;
	logic        store_we;
	logic [2:0]  store_idx;
	logic [2:0]  store_slot;
	logic [47:0] store_data;
	logic        inject;
	fetch_line_t inject_line;
	logic        inject_taken;
	pc_tagged_t  pc;
	logic        hit;
	fetch_line_t line;
	logic        en;

	// ====================
	// Configuration and address
	// ====================

	fetch_cfg_regs u_cfg (
		.clk            (clk),
		.rst            (rst),
		.cfg_valid_i    (cfg_valid_i),
		.cfg_wr_i       (cfg_wr_i),
		.restart_o      (restart),
		.restart_pc_o   (restart_pc),
		.kept_stream_o  (kept_stream),
		.store_we_o     (store_we),
		.store_idx_o    (store_idx),
		.store_slot_o   (store_slot),
		.store_data_o   (store_data),
		.inject_o       (inject),
		.inject_line_o  (inject_line),
		.inject_taken_i (inject_taken)
	);

	fetch_addr_gen u_addr_gen (
		.clk           (clk),
		.rst           (rst),
		.en_i          (en),
		.restart_i     (restart),
		.restart_pc_i  (restart_pc),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (pc)
	);

	// ====================
	// Store and stage
	// ====================

	// The store only needs the byte address, the stream is checked in the stage
	fetch_line_store u_store (
		.clk    (clk),
		.rst    (rst),
		.we_i   (store_we),
		.idx_i  (store_idx),
		.slot_i (store_slot),
		.data_i (store_data),
		.pc_i   (pc.pc),
		.hit_o  (hit),
		.line_o (line)
	);

	fetch_stage u_stage (
		.clk            (clk),
		.rst            (rst),
		.pc_i           (pc),
		.hit_i          (hit),
		.line_i         (line),
		.inject_i       (inject),
		.inject_line_i  (inject_line),
		.inject_taken_o (inject_taken),
		.kept_stream_i  (kept_stream),
		.flush_i        (flush_i),
		.irq_i          (irq_i),
		.uop_num_i      (uop_num_i),
		.bundle_valid_o (bundle_valid_o),
		.bundle_ready_i (bundle_ready_i),
		.bundle_o       (bundle_o),
		.en_o           (en)
	);

endmodule

`default_nettype wire

// File: include/fetch_macros.svh
// Fixed line geometry for the fetch front end; slot and store sizes are not parameters anywhere
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Number of instruction slots in one fetch line
`define FETCH_SLOTS 5

// Every instruction is six bytes wide
`define FETCH_SLOT_BYTES 6

// One line is five slots of six bytes
`define FETCH_LINE_BYTES 30

// Depth of the small instruction-line store
`define FETCH_STORE_LINES 8

// Opcode placed in every slot of a squashed line
`define FETCH_OP_NOP 7'h7f

`endif

// File: project.f
+incdir+include
hw/fetch_line_pkg.sv
hw/fetch_addr_pkg.sv
hw/fetch_cfg_regs.sv
hw/fetch_addr_gen.sv
hw/fetch_line_store.sv
hw/fetch_stage.sv
hw/fetch_top.sv
testbench/fetch_tb.sv

// File: testbench/fetch_cases.hex
// Columns: op(2) arg(8) data(12) expected(4); ops 01 cfg write arg=sel/idx/slot, 02 redirect, 03 flush
// 04 irq arg=uop, 05 run expected=bundles, 06 held pc arg=pc expected=stream, 07 load line, 08 inject
07_00000000_a5a5c3c30000_0000
07_00000001_a5a5c3c30000_0000
07_00000002_a5a5c3c30000_0000
07_00000003_a5a5c3c30000_0000
01_00000000_000000000000_0000
01_00000400_000000000000_0000
06_00000000_000000000000_0001
05_00000000_000000000000_0006
06_00000096_000000000000_0001
02_0000001e_000000000000_0000
05_00000000_000000000000_0003
01_00000100_000000000002_0000
01_00000400_000000000000_0000
06_0000005a_000000000000_0002
03_00000000_000000000000_0000
05_00000000_000000000000_0003
04_00000005_000000000000_0000
01_00000400_000000000000_0000
05_00000000_000000000000_0002
08_00000000_0123456789ab_0000
05_00000000_000000000000_0004
01_00000400_000000000000_0000
05_00000000_000000000000_0008
06_000000d2_000000000000_0002
00_00000000_000000000000_0000

// File: testbench/fetch_tb.sv
// Run from the project root so the case file is found; ops other than run are issued while stalled
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb
	import fetch_addr_pkg::*;
	import fetch_line_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CASES = 64;

	// Op code, argument, data word and expected value of one case
	typedef struct packed {
		logic [7:0]  op;
		logic [31:0] arg;
		logic [47:0] data;
		logic [15:0] expv;
	} case_t;

	logic          clk;
	logic          rst;
	logic          cfg_valid;
	cfg_wr_t       cfg_wr;
	logic          redirect;
	fetch_addr_t   redirect_pc;
	logic          flush;
	logic          irq;
	logic [2:0]    uop_num;
	logic          bundle_valid;
	logic          bundle_ready;
	fetch_bundle_t bundle;

	logic [103:0]  case_mem [MAX_CASES];
	int            ncases;
	int            n_checked;

	// Reference model state
	logic [47:0]   store_data [`FETCH_STORE_LINES][`FETCH_SLOTS];
	logic          store_loaded [`FETCH_STORE_LINES];
	fetch_line_t   inj_line;
	logic          inj_armed;
	fetch_addr_t   restart_pc;
	fetch_addr_t   gen_pc;
	stream_t       gen_stream;
	stream_t       kept;
	logic          flush_pend;
	logic          irq_pend;
	logic [2:0]    irq_uop;
	fetch_bundle_t held;

	fetch_top u_fetch_top (
		.clk            (clk),
		.rst            (rst),
		.cfg_valid_i    (cfg_valid),
		.cfg_wr_i       (cfg_wr),
		.redirect_i     (redirect),
		.redirect_pc_i  (redirect_pc),
		.flush_i        (flush),
		.irq_i          (irq),
		.uop_num_i      (uop_num),
		.bundle_valid_o (bundle_valid),
		.bundle_ready_i (bundle_ready),
		.bundle_o       (bundle)
	);

	always #10 clk = ~clk;

	// ====================
	// Checks
	// ====================

	task automatic compare(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_bundle(input string name);
		compare({name, " slot pc"}, 256'(held.slot_pc), 256'(bundle.slot_pc));
		compare({name, " line"}, 256'(held.line), 256'(bundle.line));
		compare({name, " flags"},
			256'({held.flush, held.irq, held.uop_num, held.squashed}),
			256'({bundle.flush, bundle.irq, bundle.uop_num, bundle.squashed}));
		n_checked++;
	endtask

	// ====================
	// Reference model
	// ====================

	// Each slot of each line gets its own word, so a wrong index or slot shows up
	function automatic logic [47:0] fill_word(input logic [47:0] base, input logic [2:0] idx,
			input int s);
		return base ^ (48'(int'(idx) * `FETCH_SLOTS + s + 1) * 48'h0001_0001_0001);
	endfunction

	function automatic insn_slot_u nop_slot();
		insn_slot_u n;
		n.f.opcode  = `FETCH_OP_NOP;
		n.f.marker  = 1'b0;
		n.f.operand = '0;
		return n;
	endfunction

	// Predicts the bundle that the stage latches on an enabled cycle, then steps the address
	task automatic latch_next();
		logic [2:0] li;
		logic       hit;
		logic       squash;
		li  = 3'(gen_pc / 32'(`FETCH_LINE_BYTES));
		// Only line-aligned addresses inside the store can hit a loaded line
		hit = (gen_pc % 32'(`FETCH_LINE_BYTES) == 0) &&
			(gen_pc < 32'(`FETCH_LINE_BYTES * `FETCH_STORE_LINES)) && store_loaded[li];
		squash = !hit || flush_pend || (gen_stream != kept);
		for (int s = 0; s < `FETCH_SLOTS; s++) begin
			held.slot_pc[3'(s)].stream = gen_stream;
			held.slot_pc[3'(s)].pc     = gen_pc + 32'(s * `FETCH_SLOT_BYTES);
			if (inj_armed) begin
				held.line[3'(s)]          = inj_line[3'(s)];
				held.line[3'(s)].f.marker = 1'b1;
			end else if (squash) begin
				held.line[3'(s)] = nop_slot();
			end else begin
				held.line[3'(s)].raw = store_data[li][3'(s)];
			end
		end
		held.squashed = !inj_armed && squash;
		held.flush    = flush_pend;
		held.irq      = irq_pend;
		held.uop_num  = irq_pend ? irq_uop : 3'd0;
		inj_armed  = 1'b0;
		flush_pend = 1'b0;
		irq_pend   = 1'b0;
		gen_pc     = gen_pc + 32'(`FETCH_LINE_BYTES);
	endtask

	// ====================
	// Drivers
	// ====================

	task automatic cfg_write(input cfg_sel_e sel, input logic [2:0] idx,
			input logic [2:0] slot, input logic [47:0] data);
		cfg_valid   = 1'b1;
		cfg_wr.sel  = sel;
		cfg_wr.idx  = idx;
		cfg_wr.slot = slot;
		cfg_wr.data = data;
		@(negedge clk);
		cfg_valid = 1'b0;
		case (sel)
			CFG_RESTART: restart_pc = data[31:0];
			CFG_KEPT:    kept = data[3:0];
			CFG_STORE: begin
				store_data[idx][slot] = data;
				if (slot == 3'd0)
					store_loaded[idx] = 1'b1;
			end
			CFG_INJECT: begin
				inj_line[slot].raw = data;
				if (slot == 3'(`FETCH_SLOTS - 1))
					inj_armed = 1'b1;
			end
			// Restart keeps the stream
			CFG_GO:      gen_pc = restart_pc;
			default: ;
		endcase
	endtask

	task automatic load_line(input logic [2:0] idx, input logic [47:0] base);
		for (int s = 0; s < `FETCH_SLOTS; s++)
			cfg_write(CFG_STORE, idx, 3'(s), fill_word(base, idx, s));
	endtask

	// Marker bits go in clear so only the stage can set them
	task automatic load_inject(input logic [47:0] base);
		insn_slot_u w;
		for (int s = 0; s < `FETCH_SLOTS; s++) begin
			w.raw      = fill_word(base, 3'd7, s);
			w.f.marker = 1'b0;
			cfg_write(CFG_INJECT, 3'd0, 3'(s), w.raw);
		end
	endtask

	task automatic redirect_pulse(input fetch_addr_t target);
		redirect    = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		redirect    = 1'b0;
		redirect_pc = '0;
		gen_pc      = target;
		gen_stream  = gen_stream + stream_t'(1);
	endtask

	task automatic flush_pulse();
		flush = 1'b1;
		@(negedge clk);
		flush      = 1'b0;
		flush_pend = 1'b1;
	endtask

	task automatic irq_pulse(input logic [2:0] uop);
		irq     = 1'b1;
		uop_num = uop;
		@(negedge clk);
		irq      = 1'b0;
		uop_num  = 3'd0;
		irq_pend = 1'b1;
		irq_uop  = uop;
	endtask

	// Outputs are read at the falling edge, where they are stable until the next rising edge
	task automatic accept_bundles(input string name, input int count);
		int   got;
		logic rdy;
		got = 0;
		while (got < count) begin
			rdy = ($urandom % 4) != 0;
			bundle_ready = rdy;
			if (bundle_valid && rdy) begin
				check_bundle($sformatf("%s bundle %0d", name, got));
				latch_next();
				got++;
			end
			@(negedge clk);
		end
		bundle_ready = 1'b0;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		case_t c;
		string name;
		int    count;
		void'($urandom(32'hf839));
		clk          = 1'b0;
		rst          = 1'b1;
		cfg_valid    = 1'b0;
		cfg_wr       = '0;
		redirect     = 1'b0;
		redirect_pc  = '0;
		flush        = 1'b0;
		irq          = 1'b0;
		uop_num      = 3'd0;
		bundle_ready = 1'b0;
		n_checked    = 0;
		for (int i = 0; i < `FETCH_STORE_LINES; i++)
			store_loaded[i] = 1'b0;
		inj_armed  = 1'b0;
		restart_pc = '0;
		gen_pc     = '0;
		gen_stream = stream_t'(1);
		kept       = stream_t'(1);
		flush_pend = 1'b0;
		irq_pend   = 1'b0;
		irq_uop    = 3'd0;
		$readmemh("testbench/fetch_cases.hex", case_mem);
		count = 0;
		while (count < MAX_CASES && case_mem[count][103:96] !== 8'h00)
			count++;
		ncases = count;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// The output register is empty while reset is held
		compare("reset valid", 256'(1'b0), 256'(bundle_valid));
		rst = 1'b0;
		// The empty output register takes the line at address 0 right after reset
		latch_next();
		while (!bundle_valid)
			@(negedge clk);
		for (int i = 0; i < ncases; i++) begin
			c    = case_t'(case_mem[i]);
			name = $sformatf("case %0d op %0h", i, c.op);
			case (c.op)
				8'h01: cfg_write(cfg_sel_e'(c.arg[10:8]), c.arg[6:4], c.arg[2:0], c.data);
				8'h02: redirect_pulse(c.arg);
				8'h03: flush_pulse();
				8'h04: irq_pulse(c.arg[2:0]);
				8'h05: accept_bundles(name, int'(c.expv));
				8'h06: compare({name, " held pc"}, 256'({c.expv[3:0], c.arg}),
					256'(bundle.slot_pc[0]));
				8'h07: load_line(c.arg[2:0], c.data);
				8'h08: load_inject(c.data);
				default: begin
					$display("Unknown operation %h in case %0d of the case file", c.op, i);
					$display("TEST FAIL");
					$fatal(1, "bad case file");
				end
			endcase
		end
		if (n_checked > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("No bundle was checked, the case file holds no run");
			$display("TEST FAIL");
			$fatal(1, "empty run");
		end
	end

	// Each case gets 200 ns
	initial begin
		wait (ncases > 0);
		#(ncases * 200);
		$display("Simulation timed out after %0d ns for %0d cases", ncases * 200, ncases);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
